/* dtw_accel_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// dtw accelerator shared definitions
// register map, id words, widths and the control word layout
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package dtw_accel_pkg;

    // datapath and register widths
    localparam int SAMPLE_W   = 16;
    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 4;

    // default sizes handed down by the top level
    localparam int REF_DEPTH_DEF  = 1024;
    localparam int FIFO_DEPTH_DEF = 4;

    // word addresses on the register port
    localparam logic [REG_ADDR_W-1:0] REG_CONTROL   = 4'd0;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 4'd1;
    localparam logic [REG_ADDR_W-1:0] REG_REF_LEN   = 4'd2;
    localparam logic [REG_ADDR_W-1:0] REG_VERSION   = 4'd3;
    localparam logic [REG_ADDR_W-1:0] REG_KEY       = 4'd4;
    localparam logic [REG_ADDR_W-1:0] REG_REF_ADDR  = 4'd5;
    localparam logic [REG_ADDR_W-1:0] REG_REF_DOUT  = 4'd7;
    localparam logic [REG_ADDR_W-1:0] REG_CYCLE_CNT = 4'd8;

    // version fields
    localparam logic [3:0] VER_MAJOR = 4'd1;
    localparam logic [7:0] VER_MINOR = 8'd0;
    localparam logic [3:0] VER_REV   = 4'd0;

    // major in the top nibble, low half is padding
    localparam logic [REG_W-1:0] VERSION_WORD = {VER_MAJOR, VER_MINOR, VER_REV, 16'h0000};
    localparam logic [REG_W-1:0] KEY_WORD     = 32'h0ca7cafe;

    // control register seen as a raw word or as its bit fields
    typedef union packed {
        logic [REG_W-1:0] raw;
        struct packed {
            // upper bits kept for readback only
            logic [REG_W-3:0] spare;
            logic             run;
            logic             core_rst;
        } f;
    } dtw_ctrl_u;

endpackage

`default_nettype wire

/* sample_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// sample FIFO between the source port and the loader
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module sample_fifo #(
    parameter int  FIFO_DEPTH = dtw_accel_pkg::FIFO_DEPTH_DEF,
    localparam int PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
    input  wire                                 S_AXI_clk,
    input  wire                                 w_axi_rst,
    input  wire                                 i_clear,
    input  wire                                 i_wr,
    input  wire  [dtw_accel_pkg::SAMPLE_W-1:0]  i_wdata,
    output logic                                o_full,
    input  wire                                 i_rd,
    output logic [dtw_accel_pkg::SAMPLE_W-1:0]  o_rdata,
    output logic                                o_empty
);
    import dtw_accel_pkg::*;

    logic [SAMPLE_W-1:0] r_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    r_wr_ptr;
    logic [PTR_W-1:0]    r_rd_ptr;
    logic [CNT_W-1:0]    r_count;

    // sample storage
    always_ff @(posedge S_AXI_clk) begin
        if (i_wr) begin
            r_mem[r_wr_ptr] <= i_wdata;
        end
    end

    // pointers wrap at depth and clear empties in one cycle
    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_clear) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (i_wr) begin
                r_wr_ptr <= (r_wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : r_wr_ptr + PTR_W'(1);
            end
            if (i_rd) begin
                r_rd_ptr <= (r_rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : r_rd_ptr + PTR_W'(1);
            end
            // occupancy holds on simultaneous push and pop
            case ({i_wr, i_rd})
                2'b10:   r_count <= r_count + CNT_W'(1);
                2'b01:   r_count <= r_count - CNT_W'(1);
                default: r_count <= r_count;
            endcase
        end
    end

    // head word visible straight from the array
    assign o_rdata = r_mem[r_rd_ptr];
    assign o_full  = (r_count == CNT_W'(FIFO_DEPTH));
    assign o_empty = (r_count == '0);

endmodule

`default_nettype wire

/* ref_mem.sv */
////////////////////////////////////////////////////////////////////////////
// reference sample memory, one write port and a registered read port
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module ref_mem #(
    parameter int  REF_DEPTH = dtw_accel_pkg::REF_DEPTH_DEF,
    localparam int PTR_W     = $clog2(REF_DEPTH)
) (
    input  wire                                 S_AXI_clk,
    input  wire                                 i_we,
    input  wire  [PTR_W-1:0]                    i_waddr,
    input  wire  [dtw_accel_pkg::SAMPLE_W-1:0]  i_wdata,
    input  wire  [PTR_W-1:0]                    i_raddr,
    output logic [dtw_accel_pkg::SAMPLE_W-1:0]  o_rdata
);
    import dtw_accel_pkg::*;

    logic [SAMPLE_W-1:0] r_mem [REF_DEPTH];

    // write from the loader, read for host readback
    always_ff @(posedge S_AXI_clk) begin
        if (i_we) begin
            r_mem[i_waddr] <= i_wdata;
        end
        // read data lags the address by one edge
        o_rdata <= r_mem[i_raddr];
    end

endmodule

`default_nettype wire

/* dtw_ref_loader.sv */
////////////////////////////////////////////////////////////////////////////
// reference loader FSM
// flushes the sample FIFO then copies ref_len samples into memory
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module dtw_ref_loader #(
    parameter int  REF_DEPTH = dtw_accel_pkg::REF_DEPTH_DEF,
    localparam int PTR_W     = $clog2(REF_DEPTH),
    localparam int LEN_W     = PTR_W + 1
) (
    input  wire                                 S_AXI_clk,
    input  wire                                 w_axi_rst,
    input  wire                                 i_core_rst,
    input  wire                                 i_run,
    input  wire  [LEN_W-1:0]                    i_ref_len,
    input  wire                                 i_fifo_empty,
    input  wire  [dtw_accel_pkg::SAMPLE_W-1:0]  i_fifo_data,
    output logic                                o_fifo_clear,
    output logic                                o_fifo_rd,
    output logic                                o_mem_we,
    output logic [PTR_W-1:0]                    o_mem_waddr,
    output logic [dtw_accel_pkg::SAMPLE_W-1:0]  o_mem_wdata,
    output logic                                o_busy,
    output logic                                o_load_done
);

    // state encoding
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_CLEAR = 2'd1;
    localparam logic [1:0] ST_LOAD  = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    logic [1:0]       r_state;
    logic [LEN_W-1:0] r_wr_cnt;
    logic             w_take;

    // one sample per edge while loading and data is waiting
    assign w_take = (r_state == ST_LOAD) && !i_fifo_empty;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_core_rst) begin
            r_state  <= ST_IDLE;
            r_wr_cnt <= '0;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (i_run) begin
                        r_state <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    // restart at address 0, empty reference skips the load
                    r_wr_cnt <= '0;
                    r_state  <= (i_ref_len == '0) ? ST_DONE : ST_LOAD;
                end
                ST_LOAD: begin
                    if (w_take) begin
                        r_wr_cnt <= r_wr_cnt + LEN_W'(1);
                        // last sample written this edge
                        if (r_wr_cnt == i_ref_len - LEN_W'(1)) begin
                            r_state <= ST_DONE;
                        end
                    end
                end
                default: begin
                    // hold done until the host drops run
                    if (!i_run) begin
                        r_state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // fifo and memory steering
    assign o_fifo_clear = (r_state == ST_CLEAR);
    assign o_fifo_rd    = w_take;
    assign o_mem_we     = w_take;
    assign o_mem_waddr  = r_wr_cnt[PTR_W-1:0];
    assign o_mem_wdata  = i_fifo_data;

    // status
    assign o_busy      = (r_state == ST_CLEAR) || (r_state == ST_LOAD);
    assign o_load_done = (r_state == ST_DONE);

endmodule

`default_nettype wire

/* dtw_cycle_counter.sv */
////////////////////////////////////////////////////////////////////////////
// load timer, counts the busy cycles of the most recent load
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module dtw_cycle_counter (
    input  wire                              S_AXI_clk,
    input  wire                              w_axi_rst,
    input  wire                              i_core_rst,
    input  wire                              i_busy,
    output logic [dtw_accel_pkg::REG_W-1:0]  o_count
);
    import dtw_accel_pkg::*;

    logic r_busy_q;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_core_rst) begin
            r_busy_q <= 1'b0;
            o_count  <= '0;
        end else begin
            r_busy_q <= i_busy;
            // new load starts, its first busy cycle counts too
            if (i_busy && !r_busy_q) begin
                o_count <= REG_W'(1);
            end else if (i_busy) begin
                o_count <= o_count + REG_W'(1);
            end
            // otherwise hold the last duration
        end
    end

endmodule

`default_nettype wire

/* dtw_reg_bank.sv */
////////////////////////////////////////////////////////////////////////////
// host register bank behind a four-phase req/ack port
// control, length and address registers plus status and readback mux
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module dtw_reg_bank #(
    parameter int  REF_DEPTH = dtw_accel_pkg::REF_DEPTH_DEF,
    localparam int PTR_W     = $clog2(REF_DEPTH),
    localparam int LEN_W     = PTR_W + 1
) (
    input  wire                                   S_AXI_clk,
    input  wire                                   w_axi_rst,
    // host side
    input  wire                                   i_reg_req,
    input  wire                                   i_reg_wr,
    input  wire  [dtw_accel_pkg::REG_ADDR_W-1:0]  i_reg_addr,
    input  wire  [dtw_accel_pkg::REG_W-1:0]       i_reg_wdata,
    output logic                                  o_reg_ack,
    output logic [dtw_accel_pkg::REG_W-1:0]       o_reg_rdata,
    output logic                                  o_reg_err,
    // core side
    output logic                                  o_core_rst,
    output logic                                  o_run,
    output logic [LEN_W-1:0]                      o_ref_len,
    input  wire                                   i_busy,
    input  wire                                   i_load_done,
    input  wire                                   i_fifo_empty,
    input  wire                                   i_fifo_full,
    input  wire  [dtw_accel_pkg::REG_W-1:0]       i_cycle_count,
    output logic [PTR_W-1:0]                      o_ref_raddr,
    input  wire  [dtw_accel_pkg::SAMPLE_W-1:0]    i_ref_rdata
);
    import dtw_accel_pkg::*;

    dtw_ctrl_u        r_ctrl;
    logic [LEN_W-1:0] r_ref_len;
    logic [PTR_W-1:0] r_ref_addr;
    logic [REG_W-1:0] w_status;
    logic [REG_W-1:0] w_rd_mux;
    logic             w_addr_ok;
    logic             w_access;

    // new access on req high while ack still low
    assign w_access = i_reg_req && !o_reg_ack;

    // status word, upper bits read as zero
    assign w_status = {{(REG_W - 4){1'b0}}, i_fifo_full, i_fifo_empty, i_load_done, i_busy};

    // address decode and read mux
    always_comb begin
        w_addr_ok = 1'b1;
        w_rd_mux  = '0;
        case (i_reg_addr)
            REG_CONTROL:   w_rd_mux = r_ctrl.raw;
            REG_STATUS:    w_rd_mux = w_status;
            REG_REF_LEN:   w_rd_mux = REG_W'(r_ref_len);
            REG_VERSION:   w_rd_mux = VERSION_WORD;
            REG_KEY:       w_rd_mux = KEY_WORD;
            REG_REF_ADDR:  w_rd_mux = REG_W'(r_ref_addr);
            REG_REF_DOUT:  w_rd_mux = REG_W'(i_ref_rdata);
            REG_CYCLE_CNT: w_rd_mux = i_cycle_count;
            default:       w_addr_ok = 1'b0;
        endcase
    end

    // handshake, error flag and register writes
    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            o_reg_ack  <= 1'b0;
            o_reg_err  <= 1'b0;
            r_ctrl.raw <= '0;
            r_ref_len  <= '0;
            r_ref_addr <= '0;
        end else if (w_access) begin
            o_reg_ack <= 1'b1;
            o_reg_err <= !w_addr_ok;
            // read-only and unmapped addresses ignore writes
            if (i_reg_wr) begin
                case (i_reg_addr)
                    REG_CONTROL:  r_ctrl.raw <= i_reg_wdata;
                    REG_REF_LEN:  r_ref_len  <= i_reg_wdata[LEN_W-1:0];
                    REG_REF_ADDR: r_ref_addr <= i_reg_wdata[PTR_W-1:0];
                    default:      r_ref_len  <= r_ref_len;
                endcase
            end
        end else if (!i_reg_req) begin
            // return to zero phase
            o_reg_ack <= 1'b0;
        end
    end

    // read data captured with the access
    always_ff @(posedge S_AXI_clk) begin
        if (w_access) begin
            o_reg_rdata <= w_rd_mux;
        end
    end

    // decoded control bits and core settings
    assign o_core_rst  = r_ctrl.f.core_rst;
    assign o_run       = r_ctrl.f.run;
    assign o_ref_len   = r_ref_len;
    assign o_ref_raddr = r_ref_addr;

endmodule

`default_nettype wire

/* dtw_accel.sv */
////////////////////////////////////////////////////////////////////////////
// dtw accelerator shell, register bank and reference loading path
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module dtw_accel #(
    parameter int  REF_DEPTH  = dtw_accel_pkg::REF_DEPTH_DEF,
    parameter int  FIFO_DEPTH = dtw_accel_pkg::FIFO_DEPTH_DEF
) (
    input  wire                                   S_AXI_clk,
    input  wire                                   w_axi_rst,
    // register port
    input  wire                                   i_reg_req,
    input  wire                                   i_reg_wr,
    input  wire  [dtw_accel_pkg::REG_ADDR_W-1:0]  i_reg_addr,
    input  wire  [dtw_accel_pkg::REG_W-1:0]       i_reg_wdata,
    output logic                                  o_reg_ack,
    output logic [dtw_accel_pkg::REG_W-1:0]       o_reg_rdata,
    output logic                                  o_reg_err,
    // sample input
    input  wire                                   i_src_valid,
    output logic                                  o_src_ready,
    input  wire  [dtw_accel_pkg::SAMPLE_W-1:0]    i_src_data
);
    import dtw_accel_pkg::*;

    localparam int PTR_W = $clog2(REF_DEPTH);
    localparam int LEN_W = PTR_W + 1;

    // control from the bank
    logic                w_core_rst;
    logic                w_run;
    logic [LEN_W-1:0]    w_ref_len;
    // fifo
    logic                w_fifo_clear;
    logic                w_fifo_wr;
    logic                w_fifo_rd;
    logic                w_fifo_full;
    logic                w_fifo_empty;
    logic [SAMPLE_W-1:0] w_fifo_data;
    // loader and memory
    logic                w_ldr_clear;
    logic                w_mem_we;
    logic [PTR_W-1:0]    w_mem_waddr;
    logic [SAMPLE_W-1:0] w_mem_wdata;
    logic [PTR_W-1:0]    w_mem_raddr;
    logic [SAMPLE_W-1:0] w_mem_rdata;
    logic                w_busy;
    logic                w_load_done;
    logic [REG_W-1:0]    w_cycle_count;

    // source accepted whenever the fifo has room
    assign o_src_ready  = !w_fifo_full;
    assign w_fifo_wr    = i_src_valid && !w_fifo_full;
    // soft reset also flushes the fifo
    assign w_fifo_clear = w_core_rst || w_ldr_clear;

    dtw_reg_bank #(.REF_DEPTH(REF_DEPTH)) i_dtw_reg_bank (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst),
        .i_reg_req(i_reg_req), .i_reg_wr(i_reg_wr), .i_reg_addr(i_reg_addr),
        .i_reg_wdata(i_reg_wdata), .o_reg_ack(o_reg_ack), .o_reg_rdata(o_reg_rdata),
        .o_reg_err(o_reg_err), .o_core_rst(w_core_rst), .o_run(w_run),
        .o_ref_len(w_ref_len), .i_busy(w_busy), .i_load_done(w_load_done),
        .i_fifo_empty(w_fifo_empty), .i_fifo_full(w_fifo_full),
        .i_cycle_count(w_cycle_count), .o_ref_raddr(w_mem_raddr), .i_ref_rdata(w_mem_rdata)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_sample_fifo (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst), .i_clear(w_fifo_clear),
        .i_wr(w_fifo_wr), .i_wdata(i_src_data), .o_full(w_fifo_full),
        .i_rd(w_fifo_rd), .o_rdata(w_fifo_data), .o_empty(w_fifo_empty)
    );

    dtw_ref_loader #(.REF_DEPTH(REF_DEPTH)) i_dtw_ref_loader (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst), .i_core_rst(w_core_rst),
        .i_run(w_run), .i_ref_len(w_ref_len), .i_fifo_empty(w_fifo_empty),
        .i_fifo_data(w_fifo_data), .o_fifo_clear(w_ldr_clear), .o_fifo_rd(w_fifo_rd),
        .o_mem_we(w_mem_we), .o_mem_waddr(w_mem_waddr), .o_mem_wdata(w_mem_wdata),
        .o_busy(w_busy), .o_load_done(w_load_done)
    );

    dtw_cycle_counter i_dtw_cycle_counter (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst), .i_core_rst(w_core_rst),
        .i_busy(w_busy), .o_count(w_cycle_count)
    );

    // host readback through the bank's address register
    ref_mem #(.REF_DEPTH(REF_DEPTH)) i_ref_mem (
        .S_AXI_clk(S_AXI_clk), .i_we(w_mem_we), .i_waddr(w_mem_waddr),
        .i_wdata(w_mem_wdata), .i_raddr(w_mem_raddr), .o_rdata(w_mem_rdata)
    );

endmodule

`default_nettype wire

/* tb_dtw_accel.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the dtw accelerator shell
// register map, back-pressure, reference load, readback and restart
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_dtw_accel;
    timeunit 1ns;
    timeprecision 1ps;

    import dtw_accel_pkg::*;

    localparam int REF_DEPTH  = REF_DEPTH_DEF;
    localparam int FIFO_DEPTH = FIFO_DEPTH_DEF;
    localparam int LOAD_LEN   = 40;
    // limit several times the whole run
    localparam int TIMEOUT_CYCLES = 20000;

    logic                  S_AXI_clk;
    logic                  w_axi_rst;
    logic                  reg_req;
    logic                  reg_wr;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_W-1:0]      reg_wdata;
    logic                  reg_ack;
    logic [REG_W-1:0]      reg_rdata;
    logic                  reg_err;
    logic                  src_valid;
    logic                  src_ready;
    logic [SAMPLE_W-1:0]   src_data;

    logic [31:0]         lfsr_state = 32'hb5a9;
    logic [SAMPLE_W-1:0] sent [LOAD_LEN];
    int                  cycle_count = 0;

    dtw_accel #(.REF_DEPTH(REF_DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) i_dtw_accel (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst),
        .i_reg_req(reg_req), .i_reg_wr(reg_wr), .i_reg_addr(reg_addr),
        .i_reg_wdata(reg_wdata), .o_reg_ack(reg_ack), .o_reg_rdata(reg_rdata),
        .o_reg_err(reg_err), .i_src_valid(src_valid), .o_src_ready(src_ready),
        .i_src_data(src_data)
    );

    // 4 ns clock
    initial begin
        S_AXI_clk = 1'b0;
        forever #2 S_AXI_clk = ~S_AXI_clk;
    end

    // run limit
    always @(posedge S_AXI_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic take_random_bits(input int n, output logic [31:0] val);
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = next_lfsr(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_at_least(input string name, input logic [31:0] minimum,
                                  input logic [31:0] actual);
        assert (actual >= minimum)
        else begin
            $display("mismatch %s expected >= %0d actual %0d", name, minimum, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // four-phase access with inputs changed on falling edges only
    task automatic access_register(input logic wr, input logic [REG_ADDR_W-1:0] addr,
                                   input logic [31:0] wdata, output logic [31:0] rdata,
                                   output logic err);
        @(negedge S_AXI_clk);
        reg_req   = 1'b1;
        reg_wr    = wr;
        reg_addr  = addr;
        reg_wdata = wdata;
        // ack rises one edge after req is sampled
        @(negedge S_AXI_clk);
        check_value($sformatf("ack rise addr %0d", addr), 32'd1, {31'd0, reg_ack});
        rdata   = reg_rdata;
        err     = reg_err;
        reg_req = 1'b0;
        // ack has to return low one edge after req drops
        @(negedge S_AXI_clk);
        check_value($sformatf("ack fall addr %0d", addr), 32'd0, {31'd0, reg_ack});
    endtask

    task automatic write_register(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        access_register(1'b1, addr, data, rdata, err);
        check_value($sformatf("write err addr %0d", addr), 32'd0, {31'd0, err});
    endtask

    task automatic read_register(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
        logic err;
        access_register(1'b0, addr, 32'd0, data, err);
        check_value($sformatf("read err addr %0d", addr), 32'd0, {31'd0, err});
    endtask

    // random idle gap then hold the sample until ready
    task automatic send_sample(input logic [SAMPLE_W-1:0] sample);
        logic [31:0] gap;
        take_random_bits(2, gap);
        repeat (gap) @(negedge S_AXI_clk);
        src_valid = 1'b1;
        src_data  = sample;
        while (!src_ready) @(negedge S_AXI_clk);
        // transfer on the rising edge in between
        @(negedge S_AXI_clk);
        src_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        logic [31:0] status;
        logic [31:0] bits;
        logic [31:0] count_a;
        logic [31:0] count_b;
        int          transfers;
        int          i;

        w_axi_rst = 1'b1;
        reg_req   = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        src_valid = 1'b0;
        src_data  = '0;
        repeat (10) @(posedge S_AXI_clk);
        @(negedge S_AXI_clk);
        w_axi_rst = 1'b0;

        // reset values
        read_register(REG_CONTROL, rdata);
        check_value("reset control", 32'h0, rdata);
        read_register(REG_STATUS, rdata);
        check_value("reset status", 32'h4, rdata);
        read_register(REG_VERSION, rdata);
        check_value("reset version", 32'h10000000, rdata);
        read_register(REG_KEY, rdata);
        check_value("reset key", 32'h0ca7cafe, rdata);

        // readback with bits 1:0 left clear so nothing starts
        write_register(REG_CONTROL, 32'hdeadbeec);
        read_register(REG_CONTROL, rdata);
        check_value("control readback", 32'hdeadbeec, rdata);
        write_register(REG_CONTROL, 32'h0);
        write_register(REG_REF_LEN, 32'h5a3);
        read_register(REG_REF_LEN, rdata);
        check_value("ref_len readback", 32'h5a3, rdata);
        // read-only write gives no err
        write_register(REG_VERSION, 32'hffffffff);
        read_register(REG_VERSION, rdata);
        check_value("version after write", 32'h10000000, rdata);
        // unmapped addresses
        access_register(1'b0, 4'd6, 32'h0, rdata, err);
        check_value("addr 6 err", 32'd1, {31'd0, err});
        check_value("addr 6 rdata", 32'h0, rdata);
        access_register(1'b1, 4'd12, 32'hffffffff, rdata, err);
        check_value("addr 12 err", 32'd1, {31'd0, err});
        check_value("addr 12 rdata", 32'h0, rdata);

        // back-pressure with run low
        transfers = 0;
        @(negedge S_AXI_clk);
        src_valid = 1'b1;
        while (src_ready) begin
            take_random_bits(SAMPLE_W, bits);
            src_data = bits[SAMPLE_W-1:0];
            @(negedge S_AXI_clk);
            transfers++;
        end
        src_valid = 1'b0;
        check_value("fifo transfers", 32'(FIFO_DEPTH), 32'(transfers));
        read_register(REG_STATUS, rdata);
        check_value("status full", 32'h8, rdata);
        // soft reset flushes the fifo
        write_register(REG_CONTROL, 32'h1);
        write_register(REG_CONTROL, 32'h0);
        read_register(REG_STATUS, rdata);
        check_value("status after core_rst", 32'h4, rdata);

        // load of LOAD_LEN samples
        write_register(REG_REF_LEN, 32'(LOAD_LEN));
        write_register(REG_CONTROL, 32'h2);
        status = '0;
        while (!status[0]) read_register(REG_STATUS, status);
        for (i = 0; i < LOAD_LEN; i++) begin
            take_random_bits(SAMPLE_W, bits);
            sent[i] = bits[SAMPLE_W-1:0];
            send_sample(sent[i]);
        end
        status = '0;
        while (!status[1]) read_register(REG_STATUS, status);
        check_value("status after load", 32'h6, status);

        // readback through ref_addr and ref_dout
        for (i = 0; i < LOAD_LEN; i++) begin
            write_register(REG_REF_ADDR, 32'(i));
            read_register(REG_REF_DOUT, rdata);
            check_value($sformatf("ref_dout[%0d]", i), {16'h0, sent[i]}, rdata);
        end
        read_register(REG_CYCLE_CNT, count_a);
        read_register(REG_CYCLE_CNT, count_b);
        check_at_least("cycle count", 32'(LOAD_LEN + 1), count_a);
        check_value("cycle count held", count_a, count_b);

        // restart with an empty reference
        write_register(REG_CONTROL, 32'h0);
        read_register(REG_STATUS, rdata);
        check_value("status after run low", 32'h4, rdata);
        write_register(REG_REF_LEN, 32'h0);
        write_register(REG_CONTROL, 32'h2);
        status = '0;
        while (!status[1]) read_register(REG_STATUS, status);
        check_value("status empty load", 32'h6, status);
        // only the clear cycle is busy
        read_register(REG_CYCLE_CNT, rdata);
        check_value("cycle count empty load", 32'h1, rdata);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dtw_accel.f */
dtw_accel_pkg.sv
sample_fifo.sv
ref_mem.sv
dtw_ref_loader.sv
dtw_cycle_counter.sv
dtw_reg_bank.sv
dtw_accel.sv
tb_dtw_accel.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dtw accelerator testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --top-module tb_dtw_accel -f dtw_accel.f -o Vtb_dtw_accel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dtw_accel > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test passed" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
